// File: source/cachePkg.sv
`default_nettype none

package cachePkg;

    // geometry of the cache. Each line holds a single 64-bit word.
    localparam int AddrBits   = 64;
    localparam int DataBits   = 64;
    localparam int MaskBits   = DataBits / 8;
    localparam int OffsetBits = 3;
    localparam int NumSets    = 8;
    localparam int IndexBits  = 3;
    localparam int TagBits    = AddrBits - IndexBits - OffsetBits;
    localparam int NumWays    = 2;

    typedef logic [DataBits-1:0]  word_t;
    typedef logic [AddrBits-1:0]  addr_t;
    typedef logic [MaskBits-1:0]  mask_t;
    typedef logic [IndexBits-1:0] index_t;
    typedef logic [TagBits-1:0]   tag_t;

    // operations accepted on the CPU request port.
    typedef enum logic [1:0] {
        OpRead,
        OpWrite,
        OpFlush
    } cacheOp;

    // controller FSM states.
    typedef enum logic [2:0] {
        StIdle,
        StLookup,
        StMemReq,
        StMemWait,
        StFlush,
        StResp
    } ctrlState;

endpackage

`default_nettype wire

// File: source/cacheBus.sv
`timescale 1ns/1ps
`default_nettype none

interface cacheBus;
    import cachePkg::*;

    addr_t  lookupAddr;
    logic   lookupEn;
    logic   fillEn;
    word_t  fillData;
    logic   writeEn;
    word_t  writeData;
    mask_t  writeMask;
    logic   invalidateEn;
    index_t invalidateIndex;

    // hit result, valid in the same cycle as lookupAddr.
    logic   hit;
    word_t  hitData;

    modport ctrl (
        output lookupAddr, lookupEn, fillEn, fillData,
        output writeEn, writeData, writeMask,
        output invalidateEn, invalidateIndex,
        input  hit, hitData
    );

    modport array (
        input  lookupAddr, lookupEn, fillEn, fillData,
        input  writeEn, writeData, writeMask,
        input  invalidateEn, invalidateIndex,
        output hit, hitData
    );

endinterface

`default_nettype wire

// File: source/cacheArray.sv
`timescale 1ns/1ps
`default_nettype none

module cacheArray (
    input logic    clk,
    input logic    rst,
    cacheBus.array bus
);
    import cachePkg::*;

    // storage per way. Valid and victim bits are control state.
    tag_t              tagMem  [NumWays][NumSets];
    word_t             dataMem [NumWays][NumSets];
    logic [NumSets-1:0] validMem [NumWays];
    logic [NumSets-1:0] victim;

    index_t             lookupIndex;
    tag_t               lookupTag;
    logic [NumWays-1:0] wayHit;
    logic               hitWay;
    logic               fillWay;

    function automatic word_t mergeBytes(word_t oldWord, word_t newWord, mask_t mask);
        word_t merged;
        merged = oldWord;
        for (int b = 0; b < MaskBits; b++) begin
            if (mask[b]) begin
                merged[8*b +: 8] = newWord[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign lookupIndex = bus.lookupAddr[OffsetBits +: IndexBits];
    assign lookupTag   = bus.lookupAddr[AddrBits-1 -: TagBits];

    // both ways are compared in parallel.
    always_comb begin
        for (int w = 0; w < NumWays; w++) begin
            wayHit[w] = validMem[w][lookupIndex] && (tagMem[w][lookupIndex] == lookupTag);
        end
    end

    assign bus.hit = |wayHit;
    assign hitWay  = wayHit[1];

    always_comb begin
        bus.hitData = '0;
        for (int w = 0; w < NumWays; w++) begin
            if (wayHit[w]) begin
                bus.hitData = dataMem[w][lookupIndex];
            end
        end
    end

    // an empty way is filled first, otherwise the victim way is replaced.
    always_comb begin
        if (!validMem[0][lookupIndex]) begin
            fillWay = 1'b0;
        end else if (!validMem[1][lookupIndex]) begin
            fillWay = 1'b1;
        end else begin
            fillWay = victim[lookupIndex];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < NumWays; w++) begin
                validMem[w] <= '0;
            end
            victim <= '0;
        end else begin
            if (bus.invalidateEn) begin
                for (int w = 0; w < NumWays; w++) begin
                    validMem[w][bus.invalidateIndex] <= 1'b0;
                end
                victim[bus.invalidateIndex] <= 1'b0;
            end
            if (bus.fillEn) begin
                validMem[fillWay][lookupIndex] <= 1'b1;
                victim[lookupIndex] <= ~fillWay;
            end
            // a read or write hit points the victim at the other way.
            if (bus.lookupEn && bus.hit) begin
                victim[lookupIndex] <= ~hitWay;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.fillEn) begin
            tagMem[fillWay][lookupIndex]  <= lookupTag;
            dataMem[fillWay][lookupIndex] <= bus.fillData;
        end
        // a write miss leaves the array alone.
        if (bus.writeEn && bus.hit) begin
            dataMem[hitWay][lookupIndex] <= mergeBytes(dataMem[hitWay][lookupIndex],
                                                       bus.writeData, bus.writeMask);
        end
    end

endmodule

`default_nettype wire

// File: source/sweepCounter.sv
`timescale 1ns/1ps
`default_nettype none

module sweepCounter (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    output cachePkg::index_t index,
    output logic            last
);
    import cachePkg::*;

    logic running;

    // the index wraps back to zero after the last set.
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            index   <= '0;
        end else if (start) begin
            running <= 1'b1;
            index   <= '0;
        end else if (running) begin
            index <= index + 1'b1;
            if (last) begin
                running <= 1'b0;
            end
        end
    end

    assign last = running && (index == index_t'(NumSets - 1));

endmodule

`default_nettype wire

// File: source/cacheController.sv
`timescale 1ns/1ps
`default_nettype none

module cacheController (
    input  logic             clk,
    input  logic             rst,

    input  logic             reqValid,
    output logic             reqReady,
    input  cachePkg::cacheOp reqOp,
    input  cachePkg::addr_t  reqAddr,
    input  cachePkg::word_t  reqWdata,
    input  cachePkg::mask_t  reqMask,

    output logic             respValid,
    output cachePkg::word_t  respData,
    output logic             respHit,

    output logic             memReqValid,
    input  logic             memReqReady,
    output logic             memWrite,
    output cachePkg::addr_t  memAddr,
    output cachePkg::word_t  memWdata,
    output cachePkg::mask_t  memMask,
    input  logic             memRespValid,
    input  cachePkg::word_t  memRespData,

    cacheBus.ctrl            bus,

    output logic             sweepStart,
    input  cachePkg::index_t sweepIndex,
    input  logic             sweepLast
);
    import cachePkg::*;

    ctrlState state;

    cacheOp opQ;
    addr_t  addrQ;
    word_t  wdataQ;
    mask_t  maskQ;

    logic accept;
    logic isRead;
    logic isWrite;
    logic isFlush;

    assign reqReady = (state == StIdle);
    assign accept   = reqValid && reqReady;
    assign isRead   = (opQ == OpRead);
    assign isWrite  = (opQ == OpWrite);
    assign isFlush  = (opQ == OpFlush);

    always_ff @(posedge clk) begin
        if (accept) begin
            opQ    <= reqOp;
            addrQ  <= reqAddr;
            wdataQ <= reqWdata;
            maskQ  <= reqMask;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= StIdle;
            respValid   <= 1'b0;
            memReqValid <= 1'b0;
        end else begin
            respValid <= 1'b0;
            case (state)
                StIdle: begin
                    if (accept) state <= StLookup;
                end
                StLookup: begin
                    if (isFlush) begin
                        state <= StFlush;
                    end else if (isRead && bus.hit) begin
                        state <= StResp;
                    end else begin
                        state <= StMemReq;
                    end
                end
                // the request is raised one cycle after entry and held until taken.
                StMemReq: begin
                    if (!memReqValid) begin
                        memReqValid <= 1'b1;
                    end else if (memReqReady) begin
                        memReqValid <= 1'b0;
                        state       <= StMemWait;
                    end
                end
                StMemWait: begin
                    if (memRespValid) begin
                        respValid <= 1'b1;
                        state     <= StIdle;
                    end
                end
                StFlush: begin
                    if (sweepLast) state <= StResp;
                end
                StResp: begin
                    respValid <= 1'b1;
                    state     <= StIdle;
                end
                default: state <= StIdle;
            endcase
        end
    end

    // response payload is captured at lookup and replaced by refill data on a read miss.
    always_ff @(posedge clk) begin
        if (state == StLookup) begin
            respHit  <= !isFlush && bus.hit;
            respData <= isRead ? bus.hitData : '0;
        end else if ((state == StMemWait) && memRespValid && isRead) begin
            respData <= memRespData;
        end
    end

    assign bus.lookupAddr      = addrQ;
    assign bus.lookupEn        = (state == StLookup) && !isFlush;
    assign bus.writeEn         = (state == StLookup) && isWrite;
    assign bus.writeData       = wdataQ;
    assign bus.writeMask       = maskQ;
    assign bus.fillEn          = (state == StMemWait) && memRespValid && isRead;
    assign bus.fillData        = memRespData;
    assign bus.invalidateEn    = (state == StFlush);
    assign bus.invalidateIndex = sweepIndex;

    assign sweepStart = (state == StLookup) && isFlush;

    // memory sees the word address. Reads fetch the whole word.
    assign memWrite = isWrite;
    assign memAddr  = {addrQ[AddrBits-1:OffsetBits], {OffsetBits{1'b0}}};
    assign memWdata = wdataQ;
    assign memMask  = isWrite ? maskQ : '1;

endmodule

`default_nettype wire

// File: source/dcacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTop (
    input  logic             clk,
    input  logic             rst,

    input  logic             reqValid,
    output logic             reqReady,
    input  cachePkg::cacheOp reqOp,
    input  cachePkg::addr_t  reqAddr,
    input  cachePkg::word_t  reqWdata,
    input  cachePkg::mask_t  reqMask,

    output logic             respValid,
    output cachePkg::word_t  respData,
    output logic             respHit,

    output logic             memReqValid,
    input  logic             memReqReady,
    output logic             memWrite,
    output cachePkg::addr_t  memAddr,
    output cachePkg::word_t  memWdata,
    output cachePkg::mask_t  memMask,
    input  logic             memRespValid,
    input  cachePkg::word_t  memRespData
);
    import cachePkg::*;

    logic   sweepStart;
    logic   sweepLast;
    index_t sweepIndex;

    cacheBus bus ();

    cacheController u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .reqValid     (reqValid),
        .reqReady     (reqReady),
        .reqOp        (reqOp),
        .reqAddr      (reqAddr),
        .reqWdata     (reqWdata),
        .reqMask      (reqMask),
        .respValid    (respValid),
        .respData     (respData),
        .respHit      (respHit),
        .memReqValid  (memReqValid),
        .memReqReady  (memReqReady),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memWdata     (memWdata),
        .memMask      (memMask),
        .memRespValid (memRespValid),
        .memRespData  (memRespData),
        .bus          (bus),
        .sweepStart   (sweepStart),
        .sweepIndex   (sweepIndex),
        .sweepLast    (sweepLast)
    );

    cacheArray u_array (
        .clk (clk),
        .rst (rst),
        .bus (bus)
    );

    sweepCounter u_sweep (
        .clk   (clk),
        .rst   (rst),
        .start (sweepStart),
        .index (sweepIndex),
        .last  (sweepLast)
    );

endmodule

`default_nettype wire

// File: tb/tbCommon.svh
// random source, reference model and compare tasks of the dcache testbench.

int          errorCount = 0;
int          checkCount = 0;
string       testName = "none";
logic [15:0] lfsrState = 16'd99;

// what memory should hold, and which lines the cache should hold.
word_t       shadowMem [addr_t];
tag_t        refTag    [NumWays][NumSets];
logic        refValid  [NumWays][NumSets];
logic        refVictim [NumSets];

// Fibonacci LFSR with taps 16, 14, 13 and 11.
function automatic logic lfsrStep();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
endfunction

function automatic word_t randBits(int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[DataBits-2:0], lfsrStep()};
    end
    return v;
endfunction

function automatic addr_t lineOf(addr_t addr);
    return (addr >> OffsetBits) << OffsetBits;
endfunction

// initial memory contents, different for every line address.
function automatic word_t fillPattern(addr_t line);
    return {line[31:0], line[63:32]} ^ (line * 64'h9E37_79B9_7F4A_7C15);
endfunction

function automatic word_t shadowRead(addr_t line);
    return shadowMem.exists(line) ? shadowMem[line] : fillPattern(line);
endfunction

function automatic word_t byteMerge(word_t oldWord, word_t newWord, mask_t mask);
    word_t keep;
    for (int b = 0; b < MaskBits; b++) begin
        keep[8*b +: 8] = {8{mask[b]}};
    end
    return (oldWord & ~keep) | (newWord & keep);
endfunction

function automatic void clearModel();
    for (int s = 0; s < NumSets; s++) begin
        refValid[0][s] = 1'b0;
        refValid[1][s] = 1'b0;
        refVictim[s]   = 1'b0;
    end
endfunction

// expected response data and hit flag; the model then moves past the request.
function automatic word_t predict(cacheOp op, addr_t addr, word_t wdata, mask_t mask,
                                  output logic hit);
    index_t set;
    tag_t   tag;
    int     way;
    set = addr[OffsetBits +: IndexBits];
    tag = addr[AddrBits-1 -: TagBits];
    way = -1;
    hit = 1'b0;
    if (op == OpFlush) begin
        clearModel();
        return '0;
    end
    for (int w = 0; w < NumWays; w++) begin
        if (refValid[w][set] && refTag[w][set] == tag) way = w;
    end
    hit = (way >= 0);
    if (hit) begin
        refVictim[set] = (way == 0);
    end else if (op == OpRead) begin
        // an empty way first, otherwise the victim.
        way = !refValid[0][set] ? 0 : (!refValid[1][set] ? 1 : int'(refVictim[set]));
        refValid[way][set] = 1'b1;
        refTag[way][set]   = tag;
        refVictim[set]     = (way == 0);
    end
    if (op == OpWrite) begin
        shadowMem[lineOf(addr)] = byteMerge(shadowRead(lineOf(addr)), wdata, mask);
        return '0;
    end
    return shadowRead(lineOf(addr));
endfunction

task automatic checkWord(string what, word_t expected, word_t actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("MISMATCH %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
endtask

task automatic checkHit(string what, logic expected, logic actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("MISMATCH %s %s: expected %b, actual %b", testName, what, expected, actual);
    end
endtask

task automatic checkMemAddr(string what, addr_t expected, addr_t actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("MISMATCH %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
endtask

task automatic checkMask(string what, mask_t expected, mask_t actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("MISMATCH %s %s: expected %b, actual %b", testName, what, expected, actual);
    end
endtask

// File: tb/tbDcache.sv
`timescale 1ns/1ps
`default_nettype none

module tbDcache;
    import cachePkg::*;

    localparam int ClkPeriod    = 100;
    localparam int ResetCycles  = 16;
    localparam int MaxMemDelay  = 7;
    localparam int HitLatency   = 2;
    localparam int FlushLatency = 10;
    localparam int DirectedOps  = 25;
    localparam int RandomOps    = 300;
    localparam int CycleLimit   = ResetCycles + (DirectedOps + RandomOps) * (16 + MaxMemDelay)
                                  + (2 + RandomOps / 16) * (NumSets + 4);

    logic   clk;
    logic   rst;
    logic   reqValid;
    logic   reqReady;
    cacheOp reqOp;
    addr_t  reqAddr;
    word_t  reqWdata;
    mask_t  reqMask;
    logic   respValid;
    word_t  respData;
    logic   respHit;
    logic   memReqValid;
    logic   memReqReady;
    logic   memWrite;
    addr_t  memAddr;
    word_t  memWdata;
    mask_t  memMask;
    logic   memRespValid;
    word_t  memRespData;

    // the request in flight, as the memory model expects to see it.
    cacheOp curOp;
    addr_t  curLine;
    word_t  curWdata;
    mask_t  curMask;
    word_t  memStore [addr_t];
    int     memReqCount = 0;
    int     cycle = 0;
    int     acceptCycle = 0;
    int     latencyExp;
    int     testErrStart;
    word_t  expData [$];
    logic   expHit [$];
    int     expLatency [$];

    `include "tbCommon.svh"

    dcacheTop u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        while (cycle < CycleLimit) begin
            @(posedge clk);
            cycle++;
        end
        $display("run stopped: no result after %0d cycles", CycleLimit);
        $display("Test FAILED");
        $finish;
    end

    function automatic word_t memRead(addr_t line);
        return memStore.exists(line) ? memStore[line] : fillPattern(line);
    endfunction

    task automatic takeMemRequest(output word_t readWord);
        memReqCount++;
        checkMemAddr("memory address", curLine, memAddr);
        if (memWrite !== (curOp == OpWrite)) begin
            errorCount++;
            $display("test %s: memory request has the wrong direction", testName);
        end
        if (memWrite) begin
            checkWord("memory write data", curWdata, memWdata);
            checkMask("memory write mask", curMask, memMask);
            memStore[memAddr] = byteMerge(memRead(memAddr), memWdata, memMask);
        end
        readWord = memRead(memAddr);
    endtask

    // memory with random ready stalls and a response delay of 0 to 7 cycles.
    initial begin
        logic  fire;
        logic  pending;
        int    delayLeft;
        word_t readWord;
        pending      = 1'b0;
        delayLeft    = 0;
        readWord     = '0;
        memReqReady  = 1'b0;
        memRespValid = 1'b0;
        memRespData  = '0;
        forever begin
            @(negedge clk);
            fire = memReqValid === 1'b1 && memReqReady;
            if (fire) takeMemRequest(readWord);
            @(posedge clk);
            #1;
            memRespValid = 1'b0;
            if (fire) begin
                pending   = 1'b1;
                delayLeft = int'(randBits(3));
            end
            if (pending && delayLeft == 0) begin
                memRespValid = 1'b1;
                memRespData  = readWord;
                pending      = 1'b0;
            end else if (pending) begin
                delayLeft--;
            end
            memReqReady = (randBits(2) != '0);
        end
    end

    // compares every response with the reference model.
    always @(negedge clk) begin
        if (!rst && respValid === 1'b1) begin
            if (expData.size() == 0) begin
                errorCount++;
                $display("test %s: response without a request", testName);
            end else begin
                checkWord("response data", expData.pop_front(), respData);
                checkHit("response hit", expHit.pop_front(), respHit);
                latencyExp = expLatency.pop_front();
                if (latencyExp >= 0 && cycle - acceptCycle != latencyExp) begin
                    errorCount++;
                    $display("test %s: response came %0d edges after acceptance, not %0d",
                             testName, cycle - acceptCycle, latencyExp);
                end
            end
        end
    end

    task automatic runOp(cacheOp op, addr_t addr, word_t wdata, mask_t mask);
        logic  hitExp;
        word_t dataExp;
        int    reqsBefore;
        int    reqsExp;
        dataExp = predict(op, addr, wdata, mask, hitExp);
        expData.push_back(dataExp);
        expHit.push_back(hitExp);
        if (op == OpFlush) expLatency.push_back(FlushLatency);
        else if (op == OpRead && hitExp) expLatency.push_back(HitLatency);
        else expLatency.push_back(-1);
        reqsExp    = (op == OpWrite || (op == OpRead && !hitExp)) ? 1 : 0;
        reqsBefore = memReqCount;
        curOp      = op;
        curLine    = lineOf(addr);
        curWdata   = wdata;
        curMask    = mask;
        @(posedge clk);
        #1;
        reqValid = 1'b1;
        reqOp    = op;
        reqAddr  = addr;
        reqWdata = wdata;
        reqMask  = mask;
        @(negedge clk);
        while (reqReady !== 1'b1) @(negedge clk);
        @(posedge clk);
        #1;
        acceptCycle = cycle;
        reqValid    = 1'b0;
        @(negedge clk);
        while (respValid !== 1'b1) @(negedge clk);
        #1;
        if (memReqCount - reqsBefore != reqsExp) begin
            errorCount++;
            $display("test %s: %0d memory requests for one operation, expected %0d",
                     testName, memReqCount - reqsBefore, reqsExp);
        end
    endtask

    task automatic beginTest(string name);
        testName     = name;
        testErrStart = errorCount;
    endtask

    task automatic endTest();
        if (errorCount == testErrStart) $display("test %s passed", testName);
        else $display("test %s failed with %0d errors", testName, errorCount - testErrStart);
    endtask

    initial begin
        cacheOp op;
        addr_t  addr;
        word_t  wdata;
        mask_t  mask;
        int     sel;
        rst      = 1'b1;
        reqValid = 1'b0;
        reqOp    = OpRead;
        reqAddr  = '0;
        reqWdata = '0;
        reqMask  = '0;
        clearModel();
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;

        beginTest("resetAndMiss");
        repeat (4) begin
            @(negedge clk);
            if (reqReady !== 1'b1 || respValid !== 1'b0 || memReqValid !== 1'b0) begin
                errorCount++;
                $display("test %s: ports are not idle after reset", testName);
            end
        end
        #1;
        runOp(OpRead, 64'h1235, '0, '0);
        runOp(OpRead, 64'h8000_0128, '0, '0);
        endTest();

        beginTest("readHit");
        runOp(OpRead, 64'h1235, '0, '0);
        runOp(OpRead, 64'h1230, '0, '0);
        runOp(OpRead, 64'h8000_0128, '0, '0);
        endTest();

        beginTest("writeThrough");
        wdata = randBits(DataBits);
        mask  = mask_t'(randBits(MaskBits));
        runOp(OpWrite, 64'h1231, wdata, mask);
        runOp(OpRead, 64'h1236, '0, '0);
        runOp(OpWrite, 64'h2240, ~wdata, ~mask);
        runOp(OpRead, 64'h2240, '0, '0);
        runOp(OpRead, 64'h2244, '0, '0);
        endTest();

        // three lines of set 2 contending for two ways.
        beginTest("replacement");
        runOp(OpRead, 64'h4010, '0, '0);
        runOp(OpRead, 64'h5010, '0, '0);
        runOp(OpRead, 64'h4010, '0, '0);
        runOp(OpRead, 64'h6010, '0, '0);
        runOp(OpRead, 64'h4010, '0, '0);
        runOp(OpRead, 64'h5010, '0, '0);
        runOp(OpRead, 64'h6010, '0, '0);
        runOp(OpRead, 64'h5010, '0, '0);
        endTest();

        beginTest("flush");
        runOp(OpFlush, '0, '0, '0);
        runOp(OpRead, 64'h1235, '0, '0);
        runOp(OpRead, 64'h8000_0128, '0, '0);
        runOp(OpRead, 64'h2244, '0, '0);
        runOp(OpRead, 64'h4010, '0, '0);
        runOp(OpRead, 64'h6010, '0, '0);
        runOp(OpRead, 64'h5010, '0, '0);
        endTest();

        beginTest("randomMix");
        for (int i = 0; i < RandomOps; i++) begin
            sel   = int'(randBits(4));
            op    = (sel == 0) ? OpFlush : ((sel < 9) ? OpRead : OpWrite);
            addr  = addr_t'(randBits(8));
            wdata = randBits(DataBits);
            mask  = mask_t'(randBits(MaskBits));
            runOp(op, addr, wdata, mask);
        end
        endTest();

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache.f
+incdir+tb
source/cachePkg.sv
source/cacheBus.sv
source/cacheArray.sv
source/sweepCounter.sv
source/cacheController.sv
source/dcacheTop.sv
tb/tbDcache.sv

// File: build.sh
#!/bin/sh
# compiles the dcache testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tbDcache \
    -Mdir obj_dir -o simDcache -f dcache.f
if [ $? -ne 0 ]; then
    echo "build.sh: Verilator compile failed"
    exit 1
fi

./obj_dir/simDcache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "build.sh: simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
fi
echo "build.sh: pass message not found in $LOG"
exit 1
